/* hw/lsu_consts.svh */
// load/store unit constants
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data memory geometry
`define MEM_SIZE   4096  // bytes, must be a multiple of 4
`define MEM_ADDR_W 12    // byte address width, log2 of MEM_SIZE

// risc-v funct3 codes shared by loads and stores
`define F3_B  3'b000  // signed byte
`define F3_H  3'b001  // signed halfword
`define F3_W  3'b010  // word
`define F3_BU 3'b100  // unsigned byte, loads only
`define F3_HU 3'b101  // unsigned halfword, loads only

// codes 3, 6 and 7 are unused by the base integer loads and stores
// and are treated as illegal in both directions

`endif

/* hw/lsu_pkg.sv */
// load/store unit types
`include "lsu_consts.svh"

package lsu_pkg;

  typedef logic [31:0] word_t;                 // data word
  typedef logic [`MEM_ADDR_W-1:0] addr_t;      // byte address into data memory
  typedef logic [2:0] funct3_t;                // access code from the instruction

  // access width after decode
  typedef enum logic [1:0] {
    BYTE     = 2'd0,
    HALFWORD = 2'd1,
    WORD     = 2'd2
  } mem_width_t;

  // reason held by the fault register
  typedef enum logic [1:0] {
    NO_FAULT         = 2'd0,
    MISALIGNED_LOAD  = 2'd1,
    MISALIGNED_STORE = 2'd2,
    ILLEGAL_ACCESS   = 2'd3
  } fault_cause_t;

endpackage

/* hw/mem_access_decode.sv */
// funct3 access decoder
`timescale 1ns/10ps
`include "lsu_consts.svh"

module mem_access_decode (
  input  logic                req,
  input  logic                write_enable,
  input  lsu_pkg::funct3_t    funct3,
  output lsu_pkg::mem_width_t width,
  output logic                sign_extend,
  output logic                store,
  output logic                illegal
);

  logic legal_load;   // code is a valid load
  logic legal_store;  // code is a valid store

  always_comb begin
    width       = lsu_pkg::BYTE;
    sign_extend = 1'b0;
    legal_load  = 1'b1;
    legal_store = 1'b0;
    case (funct3)
      `F3_B: begin
        sign_extend = 1'b1;
        legal_store = 1'b1;
      end
      `F3_H: begin
        width       = lsu_pkg::HALFWORD;
        sign_extend = 1'b1;
        legal_store = 1'b1;
      end
      `F3_W: begin
        width       = lsu_pkg::WORD;
        legal_store = 1'b1;
      end
      `F3_BU: width = lsu_pkg::BYTE;      // load only
      `F3_HU: width = lsu_pkg::HALFWORD;  // load only
      default: legal_load = 1'b0;         // 3, 6, 7
    endcase
  end

  // legality depends on direction
  assign illegal = write_enable ? !legal_store : !legal_load;

  // only legal stores reach the memory write port
  assign store = req && write_enable && !illegal;

endmodule

/* hw/data_mem.sv */
// byte-addressed data memory
`timescale 1ns/10ps
`include "lsu_consts.svh"

module data_mem (
  input  logic                clk,
  input  logic                store,
  input  lsu_pkg::mem_width_t width,
  input  logic                sign_extend,
  input  lsu_pkg::addr_t      address,
  input  lsu_pkg::word_t      data_in,
  output lsu_pkg::word_t      data_out,
  output logic                misaligned
);

  lsu_pkg::word_t mem [`MEM_SIZE/4];  // no reset, contents set by software

  logic [`MEM_ADDR_W-3:0] word_idx;   // word select
  logic [3:0][7:0]        read_word;  // addressed word split into lanes
  logic [3:0][7:0]        write_word; // merged word for the store
  logic [7:0]             byte_lane;
  logic [15:0]            half_lane;

  assign word_idx  = address[`MEM_ADDR_W-1:2];
  assign read_word = mem[word_idx];  // combinational read

  // lanes picked by the low address bits
  assign byte_lane = read_word[address[1:0]];
  assign half_lane = {read_word[{address[1], 1'b1}], read_word[{address[1], 1'b0}]};

  // alignment check
  always_comb begin
    case (width)
      lsu_pkg::HALFWORD: misaligned = address[0];
      lsu_pkg::WORD:     misaligned = |address[1:0];
      default:           misaligned = 1'b0;  // bytes are always aligned
    endcase
  end

  // read-modify-write merge of the store lanes
  always_comb begin
    write_word = read_word;
    case (width)
      lsu_pkg::BYTE: write_word[address[1:0]] = data_in[7:0];
      lsu_pkg::HALFWORD: begin
        write_word[{address[1], 1'b1}] = data_in[15:8];
        write_word[{address[1], 1'b0}] = data_in[7:0];
      end
      lsu_pkg::WORD: write_word = data_in;
      default: write_word = read_word;
    endcase
  end

  // misaligned stores are dropped here
  always_ff @(posedge clk) begin
    if (store && !misaligned) begin
      mem[word_idx] <= write_word;
    end
  end

  // load path, zero or sign extended
  always_comb begin
    case (width)
      lsu_pkg::BYTE:
        data_out = {{24{sign_extend & byte_lane[7]}}, byte_lane};
      lsu_pkg::HALFWORD:
        data_out = {{16{sign_extend & half_lane[15]}}, half_lane};
      lsu_pkg::WORD:
        data_out = read_word;
      default:
        data_out = '0;
    endcase
  end

  // decoder must hand over a defined width with every store
  store_width_valid : assert property (
    @(posedge clk) store |-> width inside {lsu_pkg::BYTE, lsu_pkg::HALFWORD, lsu_pkg::WORD}
  ) else $error("store with undefined width %0d", width);

endmodule

/* hw/access_fault_capture.sv */
// sticky access fault register
`timescale 1ns/10ps

module access_fault_capture (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  write_enable,
  input  logic                  misaligned,
  input  logic                  illegal,
  input  lsu_pkg::addr_t        address,
  input  logic                  fault_clear,
  output logic                  fault,
  output lsu_pkg::addr_t        fault_addr,
  output lsu_pkg::fault_cause_t fault_cause
);

  logic                  capture;     // first fault while register is empty
  lsu_pkg::fault_cause_t next_cause;

  assign capture = req && (misaligned || illegal) && !fault;

  // an illegal code outranks misalignment
  always_comb begin
    if (illegal) begin
      next_cause = lsu_pkg::ILLEGAL_ACCESS;
    end else if (write_enable) begin
      next_cause = lsu_pkg::MISALIGNED_STORE;
    end else begin
      next_cause = lsu_pkg::MISALIGNED_LOAD;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault       <= 1'b0;
      fault_cause <= lsu_pkg::NO_FAULT;
      fault_addr  <= '0;
    end else if (fault_clear) begin  // clear beats a same-cycle capture
      fault       <= 1'b0;
      fault_cause <= lsu_pkg::NO_FAULT;
    end else if (capture) begin
      fault       <= 1'b1;
      fault_cause <= next_cause;
      fault_addr  <= address;
    end
  end

  // cause and flag stay consistent
  cause_matches_flag : assert property (
    @(posedge clk) disable iff (!rst_n)
    (fault_cause == lsu_pkg::NO_FAULT) == !fault
  ) else $error("fault flag %0b with cause %s", fault, fault_cause.name());

  // a held fault is frozen until software clears it
  fault_is_sticky : assert property (
    @(posedge clk) disable iff (!rst_n)
    fault && !fault_clear |=> fault && $stable(fault_addr) && $stable(fault_cause)
  ) else $error("held fault changed without a clear");

endmodule

/* hw/load_store_unit.sv */
// load/store unit top
`timescale 1ns/10ps

module load_store_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  write_enable,
  input  lsu_pkg::funct3_t      funct3,
  input  lsu_pkg::addr_t        address,
  input  lsu_pkg::word_t        data_in,
  output lsu_pkg::word_t        data_out,
  input  logic                  fault_clear,
  output logic                  fault,
  output lsu_pkg::addr_t        fault_addr,
  output lsu_pkg::fault_cause_t fault_cause
);

  lsu_pkg::mem_width_t width;
  logic                sign_extend;
  logic                store;       // legal store strobe
  logic                illegal;
  logic                misaligned;

  mem_access_decode u_decode (
    .req          (req),
    .write_enable (write_enable),
    .funct3       (funct3),
    .width        (width),
    .sign_extend  (sign_extend),
    .store        (store),
    .illegal      (illegal)
  );

  data_mem u_mem (
    .clk         (clk),
    .store       (store),
    .width       (width),
    .sign_extend (sign_extend),
    .address     (address),
    .data_in     (data_in),
    .data_out    (data_out),
    .misaligned  (misaligned)
  );

  access_fault_capture u_fault (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .write_enable (write_enable),
    .misaligned   (misaligned),
    .illegal      (illegal),
    .address      (address),
    .fault_clear  (fault_clear),
    .fault        (fault),
    .fault_addr   (fault_addr),
    .fault_cause  (fault_cause)
  );

endmodule

/* test/tb_load_store_unit.sv */
// load/store unit testbench
`timescale 1ns/10ps
`include "lsu_consts.svh"

module tb_load_store_unit;

  localparam int AW             = `MEM_ADDR_W;
  localparam int N_INIT         = `MEM_SIZE / 4;  // word stores that fill the memory
  localparam int N_DIRECTED     = 194;            // directed accesses and clears
  localparam int N_RANDOM       = 400;
  localparam int TIMEOUT_CYCLES = 2 * (N_INIT + N_DIRECTED + N_RANDOM) + 100;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  write_enable;
  lsu_pkg::funct3_t      funct3;
  lsu_pkg::addr_t        address;
  lsu_pkg::word_t        data_in;
  lsu_pkg::word_t        data_out;
  logic                  fault_clear;
  logic                  fault;
  lsu_pkg::addr_t        fault_addr;
  lsu_pkg::fault_cause_t fault_cause;

  logic [7:0]            ref_mem [`MEM_SIZE];  // byte image of the data memory
  lsu_pkg::fault_cause_t exp_cause;
  lsu_pkg::addr_t        exp_addr;
  lsu_pkg::word_t        rng_state;
  int                    mismatch_count;
  int                    other_count;
  int                    cycle_count;

  load_store_unit UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .write_enable (write_enable),
    .funct3       (funct3),
    .address      (address),
    .data_in      (data_in),
    .data_out     (data_out),
    .fault_clear  (fault_clear),
    .fault        (fault),
    .fault_addr   (fault_addr),
    .fault_cause  (fault_cause)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic lsu_pkg::word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // every address bit shows up in the word
  function automatic lsu_pkg::word_t fill_word(lsu_pkg::addr_t a);
    return {a, ~a, a[7:0] ^ a[AW-1:AW-8]};
  endfunction

  function automatic logic is_illegal(logic we, lsu_pkg::funct3_t f3);
    case (f3)
      `F3_B, `F3_H, `F3_W: return 1'b0;
      `F3_BU, `F3_HU:      return we;  // unsigned codes exist for loads only
      default:             return 1'b1;
    endcase
  endfunction

  function automatic logic is_misaligned(lsu_pkg::funct3_t f3, lsu_pkg::addr_t a);
    case (f3[1:0])
      2'd1:    return a[0];
      2'd2:    return |a[1:0];
      default: return 1'b0;
    endcase
  endfunction

  // expected load result for a legal, aligned access
  function automatic lsu_pkg::word_t ref_load(lsu_pkg::funct3_t f3, lsu_pkg::addr_t a);
    logic [7:0]  b;
    logic [15:0] h;
    b = ref_mem[a];
    h = {ref_mem[{a[AW-1:1], 1'b1}], ref_mem[{a[AW-1:1], 1'b0}]};
    case (f3)
      `F3_B:   return {{24{b[7]}}, b};
      `F3_BU:  return {24'h0, b};
      `F3_H:   return {{16{h[15]}}, h};
      `F3_HU:  return {16'h0, h};
      default: return {ref_mem[{a[AW-1:2], 2'd3}], ref_mem[{a[AW-1:2], 2'd2}],
                       ref_mem[{a[AW-1:2], 2'd1}], ref_mem[{a[AW-1:2], 2'd0}]};
    endcase
  endfunction

  task automatic check_word(lsu_pkg::word_t got, lsu_pkg::word_t exp, string what);
    if ($isunknown(got)) begin
      other_count++;
      $display("at %0t the %s has unknown bits", $time, what);
    end else if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_fault(logic got_flag, lsu_pkg::fault_cause_t got_cause,
                             lsu_pkg::addr_t got_addr, lsu_pkg::fault_cause_t exp_c,
                             lsu_pkg::addr_t exp_a);
    if (got_flag !== (exp_c != lsu_pkg::NO_FAULT)) begin
      mismatch_count++;
      $display("Mismatch at %0t: fault flag got %b for cause %s", $time, got_flag, exp_c.name());
    end
    if (got_cause !== exp_c) begin
      mismatch_count++;
      $display("Mismatch at %0t: fault_cause got %s expected %s", $time, got_cause.name(),
               exp_c.name());
    end
    if (exp_c != lsu_pkg::NO_FAULT && got_addr !== exp_a) begin
      mismatch_count++;
      $display("Mismatch at %0t: fault_addr got %h expected %h", $time, got_addr, exp_a);
    end
  endtask

  // commit the access of this cycle to the model, as the coming edge does in the DUT
  task automatic apply_access();
    logic ill;
    logic mis;
    ill = is_illegal(write_enable, funct3);
    mis = is_misaligned(funct3, address);
    if (fault_clear) begin
      exp_cause = lsu_pkg::NO_FAULT;  // clear beats capture
    end else if (req && (ill || mis) && exp_cause == lsu_pkg::NO_FAULT) begin
      exp_cause = ill ? lsu_pkg::ILLEGAL_ACCESS :
                  (write_enable ? lsu_pkg::MISALIGNED_STORE : lsu_pkg::MISALIGNED_LOAD);
      exp_addr  = address;
    end
    if (req && write_enable && !ill && !mis) begin
      case (funct3[1:0])
        2'd0: ref_mem[address] = data_in[7:0];
        2'd1: begin
          ref_mem[{address[AW-1:1], 1'b1}] = data_in[15:8];
          ref_mem[{address[AW-1:1], 1'b0}] = data_in[7:0];
        end
        default: begin
          ref_mem[{address[AW-1:2], 2'd3}] = data_in[31:24];
          ref_mem[{address[AW-1:2], 2'd2}] = data_in[23:16];
          ref_mem[{address[AW-1:2], 2'd1}] = data_in[15:8];
          ref_mem[{address[AW-1:2], 2'd0}] = data_in[7:0];
        end
      endcase
    end
  endtask

  // mid-cycle compare, inputs and outputs are settled here
  always @(negedge clk) begin
    if (rst_n) begin
      check_fault(fault, fault_cause, fault_addr, exp_cause, exp_addr);
      if (req && !write_enable && !is_illegal(1'b0, funct3) && !is_misaligned(funct3, address))
        check_word(data_out, ref_load(funct3, address), "load data_out");
      apply_access();
    end
  end

  task automatic issue_access(logic we, lsu_pkg::funct3_t f3, lsu_pkg::addr_t a,
                              lsu_pkg::word_t d, logic clr);
    @(posedge clk);
    #1;
    req          = 1'b1;
    write_enable = we;
    funct3       = f3;
    address      = a;
    data_in      = d;
    fault_clear  = clr;
  endtask

  task automatic idle_cycle(logic clr);
    @(posedge clk);
    #1;
    req         = 1'b0;
    fault_clear = clr;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped after %0d cycles before the tests finished", cycle_count);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    lsu_pkg::word_t r;
    lsu_pkg::word_t d;
    lsu_pkg::addr_t a;
    lsu_pkg::addr_t w;
    rng_state      = 32'd43616;
    mismatch_count = 0;
    other_count    = 0;
    exp_cause      = lsu_pkg::NO_FAULT;
    exp_addr       = '0;
    rst_n          = 1'b0;
    req            = 1'b0;
    write_enable   = 1'b0;
    funct3         = `F3_W;
    address        = '0;
    data_in        = '0;
    fault_clear    = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < N_INIT; i++) begin
      a = lsu_pkg::addr_t'(i * 4);
      issue_access(1'b1, `F3_W, a, fill_word(a), 1'b0);
    end

    repeat (16) begin  // word round trip
      r = next_rand();
      d = next_rand();
      a = {r[AW-1:2], 2'b00};
      issue_access(1'b1, `F3_W, a, d, 1'b0);
      issue_access(1'b0, `F3_W, a, '0, 1'b0);
    end

    repeat (16) begin  // byte and halfword lane merge
      r = next_rand();
      d = next_rand();
      a = r[AW-1:0];
      w = {a[AW-1:2], 2'b00};
      issue_access(1'b1, `F3_B, a, d, 1'b0);
      issue_access(1'b0, `F3_W, w, '0, 1'b0);
      issue_access(1'b1, `F3_H, {a[AW-1:2], ~a[1], 1'b0}, ~d, 1'b0);
      issue_access(1'b0, `F3_W, w, '0, 1'b0);
    end

    repeat (16) begin  // load extension on every lane
      r = next_rand();
      d = next_rand();
      if (r[0])
        d = d | 32'h8080_8080;  // sign bit set in every byte
      w = {r[AW-1:2], 2'b00};
      issue_access(1'b1, `F3_W, w, d, 1'b0);
      issue_access(1'b0, `F3_B, {w[AW-1:2], r[5:4]}, '0, 1'b0);
      issue_access(1'b0, `F3_BU, {w[AW-1:2], r[7:6]}, '0, 1'b0);
      issue_access(1'b0, `F3_H, {w[AW-1:2], r[8], 1'b0}, '0, 1'b0);
      issue_access(1'b0, `F3_HU, {w[AW-1:2], r[9], 1'b0}, '0, 1'b0);
    end

    r = next_rand();  // misaligned stores leave memory alone
    w = {r[AW-1:2], 2'b00};
    idle_cycle(1'b1);
    issue_access(1'b1, `F3_W, {w[AW-1:2], 2'b01}, next_rand(), 1'b0);
    issue_access(1'b0, `F3_W, w, '0, 1'b0);
    idle_cycle(1'b1);
    issue_access(1'b1, `F3_H, {w[AW-1:2], 2'b11}, next_rand(), 1'b0);
    issue_access(1'b0, `F3_W, w, '0, 1'b0);

    r = next_rand();  // first fault wins, then illegal codes
    w = {r[AW-1:2], 2'b00};
    a = {r[AW-1:4], 4'b0011};
    idle_cycle(1'b1);
    issue_access(1'b1, `F3_W, {w[AW-1:2], 2'b10}, next_rand(), 1'b0);
    issue_access(1'b0, `F3_H, a, '0, 1'b0);
    issue_access(1'b0, 3'd3, a, '0, 1'b0);
    issue_access(1'b1, `F3_BU, a, next_rand(), 1'b0);
    idle_cycle(1'b1);
    issue_access(1'b1, `F3_BU, w, next_rand(), 1'b0);
    issue_access(1'b0, `F3_W, w, '0, 1'b0);
    idle_cycle(1'b1);
    issue_access(1'b1, 3'd3, w, next_rand(), 1'b0);
    issue_access(1'b0, `F3_W, w, '0, 1'b0);
    idle_cycle(1'b0);

    repeat (N_RANDOM) begin
      r = next_rand();
      d = next_rand();
      a = r[AW-1:0];
      if (r[12])
        a[1:0] = 2'b00;  // keep many accesses aligned
      issue_access(r[16], r[15:13], a, d, r[19:17] == 3'd0);
    end

    idle_cycle(1'b0);
    idle_cycle(1'b0);
    @(posedge clk);
    #2;
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+hw
hw/lsu_pkg.sv
hw/mem_access_decode.sv
hw/data_mem.sv
hw/access_fault_capture.sv
hw/load_store_unit.sv
test/tb_load_store_unit.sv

/* Makefile */
TOP = tb_load_store_unit
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): files.f hw/*.sv hw/*.svh test/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ) -f files.f

# the log decides the result, not the simulator exit code
run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	@grep -qx "STATUS: PASS" sim.log || (echo "simulation failed, see sim.log"; exit 1)

clean:
	rm -rf $(OBJ) sim.log
